// ==== common/cpuPkg.sv ====
package cpuPkg;

	// **************************************************
	// Register file sizes
	// **************************************************
	parameter int archRegs = 32;
	parameter int physRegs = 64;

	localparam int aregW = $clog2(archRegs);
	localparam int pregW = $clog2(physRegs);

	// **************************************************
	// Common address and field types
	// **************************************************
	typedef logic [aregW-1:0] aregT; // Architectural register number
	typedef logic [pregW-1:0] pregT; // Physical register number

	typedef logic [31:0] addrT;

	// Opcode as it leaves decode
	typedef logic [5:0] opT;

endpackage

// ==== common/renamePkg.sv ====
package renamePkg;

	// Registers beyond the architectural set start out free
	parameter int freeDepth = cpuPkg::physRegs - cpuPkg::archRegs;

	localparam int operandW = 16;

	// **************************************************
	// Operand field, read as a register or an immediate
	// **************************************************
	typedef struct packed {
		cpuPkg::aregT src2;
		logic [operandW-cpuPkg::aregW-1:0] pad;
	} regFormT;

	typedef union packed {
		regFormT regForm;
		logic [operandW-1:0] immForm;
	} operandU;

	// **************************************************
	// Instruction bundles
	// **************************************************
	typedef struct packed {
		logic valid;
		cpuPkg::addrT pc;
		cpuPkg::opT op;
		logic useImm; // Operand holds an immediate
		logic regWrite;
		cpuPkg::aregT dst;
		cpuPkg::aregT src1;
		operandU operand;
	} decodedInstrT;

	typedef struct packed {
		logic valid;
		cpuPkg::pregT id;
	} physSrcT;

	typedef struct packed {
		logic valid;
		cpuPkg::addrT pc;
		cpuPkg::opT op;
		logic useImm;
		logic regWrite;
		cpuPkg::aregT dst;
		cpuPkg::pregT pdst;
		cpuPkg::pregT prevPdst; // Freed by the reorder buffer at commit
		physSrcT psrc1;
		physSrcT psrc2;
		operandU operand;
	} renamedInstrT;

	// Register handed back by commit
	typedef struct packed {
		logic valid;
		cpuPkg::pregT id;
	} releaseT;

endpackage

// ==== rename/rawCheck.sv ====
`timescale 1ns/1ps

module rawCheck #(
	parameter int fetchWidth = 2
) (
	input cpuPkg::pregT [fetchWidth-1:0] ratSrc1,
	input cpuPkg::pregT [fetchWidth-1:0] ratSrc2,
	input cpuPkg::pregT [fetchWidth-1:0] ratPrev,
	input cpuPkg::pregT [fetchWidth-1:0] pdst,
	input cpuPkg::aregT [fetchWidth-1:0] src1,
	input cpuPkg::aregT [fetchWidth-1:0] src2,
	input cpuPkg::aregT [fetchWidth-1:0] dst,
	input logic [fetchWidth-1:0] writes,
	output cpuPkg::pregT [fetchWidth-1:0] psrc1,
	output cpuPkg::pregT [fetchWidth-1:0] psrc2,
	output cpuPkg::pregT [fetchWidth-1:0] prevPdst
);

	// Lower slots are scanned upward, so the nearest writer is the last match
	always_comb begin
		psrc1 = ratSrc1;
		psrc2 = ratSrc2;
		prevPdst = ratPrev;
		for (int i = 1; i < fetchWidth; i++) begin
			for (int j = 0; j < i; j++) begin
				if (writes[j]) begin
					if (dst[j] == src1[i]) begin
						psrc1[i] = pdst[j];
					end
					if (dst[j] == src2[i]) begin
						psrc2[i] = pdst[j];
					end
					// A rewrite inside the group frees the earlier slot's register
					if (dst[j] == dst[i]) begin
						prevPdst[i] = pdst[j];
					end
				end
			end
		end
	end

endmodule

// ==== rename/registerAliasTable.sv ====
`timescale 1ns/1ps

module registerAliasTable #(
	parameter int fetchWidth = 2
) (
	input logic clk,
	input logic rstN,
	input cpuPkg::aregT [fetchWidth-1:0] rdSrc1,
	input cpuPkg::aregT [fetchWidth-1:0] rdSrc2,
	input cpuPkg::aregT [fetchWidth-1:0] rdDst,
	input logic [fetchWidth-1:0] wrEn,
	input cpuPkg::aregT [fetchWidth-1:0] wrAreg,
	input cpuPkg::pregT [fetchWidth-1:0] wrPreg,
	output cpuPkg::pregT [fetchWidth-1:0] mapSrc1,
	output cpuPkg::pregT [fetchWidth-1:0] mapSrc2,
	output cpuPkg::pregT [fetchWidth-1:0] mapDst
);

	// Speculative map, one physical register per architectural one
	cpuPkg::pregT mapQ [cpuPkg::archRegs];

	// **************************************************
	// Group write port
	// **************************************************
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int r = 0; r < cpuPkg::archRegs; r++) begin
				mapQ[r] <= cpuPkg::pregT'(r); // Identity map
			end
		end else begin
			// Later assignments override earlier ones, so the highest slot wins
			for (int i = 0; i < fetchWidth; i++) begin
				if (wrEn[i]) begin
					mapQ[wrAreg[i]] <= wrPreg[i];
				end
			end
		end
	end

	// **************************************************
	// Group read ports
	// **************************************************
	for (genvar i = 0; i < fetchWidth; i++) begin : gRead
		assign mapSrc1[i] = mapQ[rdSrc1[i]];
		assign mapSrc2[i] = mapQ[rdSrc2[i]];
		assign mapDst[i] = mapQ[rdDst[i]]; // Mapping the destination held before
	end

endmodule

// ==== rename/freeList.sv ====
`timescale 1ns/1ps

module freeList #(
	parameter int fetchWidth = 2,
	localparam int allocW = $clog2(fetchWidth + 1),
	localparam int countW = $clog2(renamePkg::freeDepth + 1)
) (
	input logic clk,
	input logic rstN,
	input logic [allocW-1:0] allocCount,
	input renamePkg::releaseT [fetchWidth-1:0] releases,
	output cpuPkg::pregT [fetchWidth-1:0] freeIds,
	output logic [countW-1:0] freeCount
);

	localparam int ptrW = $clog2(renamePkg::freeDepth);

	cpuPkg::pregT queueQ [renamePkg::freeDepth];
	logic [ptrW-1:0] headQ; // Oldest free register
	logic [ptrW-1:0] tailQ; // Next slot to fill
	logic [countW-1:0] countQ;

	logic [ptrW-1:0] pushPos [fetchWidth];
	logic [allocW-1:0] pushCount;
	logic [countW-1:0] countNext;

	function automatic logic [ptrW-1:0] wrapAdd(input logic [ptrW-1:0] base, input int offset);
		int sum;
		sum = int'(base) + offset;
		if (sum >= renamePkg::freeDepth) begin
			sum = sum - renamePkg::freeDepth;
		end
		return ptrW'(sum);
	endfunction

	// **************************************************
	// Pop side
	// **************************************************
	always_comb begin
		for (int i = 0; i < fetchWidth; i++) begin
			freeIds[i] = queueQ[wrapAdd(headQ, i)];
		end
	end

	assign freeCount = countQ;

	// Valid releases are packed together in slot order
	always_comb begin
		int n;
		n = 0;
		for (int i = 0; i < fetchWidth; i++) begin
			pushPos[i] = wrapAdd(tailQ, n);
			if (releases[i].valid) begin
				n = n + 1;
			end
		end
		pushCount = allocW'(n);
	end

	assign countNext = countQ - countW'(allocCount) + countW'(pushCount);

	// **************************************************
	// Queue state
	// **************************************************
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < renamePkg::freeDepth; i++) begin
				queueQ[i] <= cpuPkg::pregT'(cpuPkg::archRegs + i);
			end
			headQ <= '0;
			tailQ <= '0; // Queue starts full so tail sits on head
			countQ <= countW'(renamePkg::freeDepth);
		end else begin
			for (int i = 0; i < fetchWidth; i++) begin
				if (releases[i].valid) begin
					queueQ[pushPos[i]] <= releases[i].id;
				end
			end
			headQ <= wrapAdd(headQ, int'(allocCount));
			tailQ <= wrapAdd(tailQ, int'(pushCount));
			countQ <= countNext;
		end
	end

endmodule

// ==== rename/renameStage.sv ====
`timescale 1ns/1ps

module renameStage #(
	parameter int fetchWidth = 2,
	localparam int allocW = $clog2(fetchWidth + 1),
	localparam int countW = $clog2(renamePkg::freeDepth + 1)
) (
	input logic clk,
	input logic rstN,
	input renamePkg::decodedInstrT [fetchWidth-1:0] decodeGroup,
	input cpuPkg::pregT [fetchWidth-1:0] mapSrc1,
	input cpuPkg::pregT [fetchWidth-1:0] mapSrc2,
	input cpuPkg::pregT [fetchWidth-1:0] mapDst,
	input cpuPkg::pregT [fetchWidth-1:0] freeIds,
	input logic [countW-1:0] freeCount,
	output cpuPkg::aregT [fetchWidth-1:0] rdSrc1,
	output cpuPkg::aregT [fetchWidth-1:0] rdSrc2,
	output cpuPkg::aregT [fetchWidth-1:0] rdDst,
	output logic [fetchWidth-1:0] wrEn,
	output cpuPkg::aregT [fetchWidth-1:0] wrAreg,
	output cpuPkg::pregT [fetchWidth-1:0] wrPreg,
	output logic [allocW-1:0] allocCount,
	output logic stall,
	output renamePkg::renamedInstrT [fetchWidth-1:0] renamedGroup
);

	cpuPkg::aregT [fetchWidth-1:0] src1, src2, dst;
	logic [fetchWidth-1:0] writes;
	cpuPkg::pregT [fetchWidth-1:0] pdst, psrc1, psrc2, prevPdst;
	logic [allocW-1:0] needCount;
	logic accept;
	renamePkg::renamedInstrT [fetchWidth-1:0] nextGroup;
	renamePkg::renamedInstrT [fetchWidth-1:0] payloadQ;
	logic [fetchWidth-1:0] validQ;

	for (genvar i = 0; i < fetchWidth; i++) begin : gFields
		assign src1[i] = decodeGroup[i].src1;
		assign src2[i] = decodeGroup[i].operand.regForm.src2; // Garbage when useImm is set
		assign dst[i] = decodeGroup[i].dst;
		assign writes[i] = decodeGroup[i].valid & decodeGroup[i].regWrite;
	end

	assign rdSrc1 = src1;
	assign rdSrc2 = src2;
	assign rdDst = dst;

	// **************************************************
	// Allocation and stall
	// **************************************************
	always_comb begin
		int n;
		n = 0;
		for (int i = 0; i < fetchWidth; i++) begin
			pdst[i] = '0;
			if (writes[i]) begin
				pdst[i] = freeIds[n]; // n-th writer takes the n-th free register
				n = n + 1;
			end
		end
		needCount = allocW'(n);
	end

	assign stall = countW'(needCount) > freeCount;
	assign accept = !stall;
	assign allocCount = accept ? needCount : '0;

	assign wrEn = writes & {fetchWidth{accept}};
	assign wrAreg = dst;
	assign wrPreg = pdst;

	rawCheck #(.fetchWidth(fetchWidth)) uRawCheck (
		.ratSrc1(mapSrc1),
		.ratSrc2(mapSrc2),
		.ratPrev(mapDst),
		.pdst,
		.src1,
		.src2,
		.dst,
		.writes,
		.psrc1,
		.psrc2,
		.prevPdst
	);

	// **************************************************
	// Renamed group and output register
	// **************************************************
	always_comb begin
		for (int i = 0; i < fetchWidth; i++) begin
			nextGroup[i].valid = decodeGroup[i].valid & accept; // Bubble on stall
			nextGroup[i].pc = decodeGroup[i].pc;
			nextGroup[i].op = decodeGroup[i].op;
			nextGroup[i].useImm = decodeGroup[i].useImm;
			nextGroup[i].regWrite = decodeGroup[i].regWrite;
			nextGroup[i].dst = decodeGroup[i].dst;
			nextGroup[i].pdst = pdst[i];
			nextGroup[i].prevPdst = writes[i] ? prevPdst[i] : '0;
			nextGroup[i].psrc1.valid = decodeGroup[i].valid;
			nextGroup[i].psrc1.id = psrc1[i];
			nextGroup[i].psrc2.valid = decodeGroup[i].valid & !decodeGroup[i].useImm;
			nextGroup[i].psrc2.id = decodeGroup[i].useImm ? '0 : psrc2[i];
			nextGroup[i].operand = decodeGroup[i].operand;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= '0;
		end else begin
			for (int i = 0; i < fetchWidth; i++) begin
				validQ[i] <= nextGroup[i].valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		payloadQ <= nextGroup;
	end

	always_comb begin
		renamedGroup = payloadQ;
		for (int i = 0; i < fetchWidth; i++) begin
			renamedGroup[i].valid = validQ[i];
		end
	end

endmodule

// ==== hdl/renameUnit.sv ====
`timescale 1ns/1ps

module renameUnit #(
	parameter int fetchWidth = 2
) (
	input logic clk,
	input logic rstN,
	input renamePkg::decodedInstrT [fetchWidth-1:0] decodeGroup,
	input renamePkg::releaseT [fetchWidth-1:0] releases,
	output renamePkg::renamedInstrT [fetchWidth-1:0] renamedGroup,
	output logic stall
);

	localparam int allocW = $clog2(fetchWidth + 1);
	localparam int countW = $clog2(renamePkg::freeDepth + 1);

	cpuPkg::aregT [fetchWidth-1:0] rdSrc1, rdSrc2, rdDst, wrAreg;
	cpuPkg::pregT [fetchWidth-1:0] mapSrc1, mapSrc2, mapDst, wrPreg;
	cpuPkg::pregT [fetchWidth-1:0] freeIds;
	logic [fetchWidth-1:0] wrEn;
	logic [allocW-1:0] allocCount;
	logic [countW-1:0] freeCount;

	// **************************************************
	// Stage, map table and free list
	// **************************************************
	renameStage #(.fetchWidth(fetchWidth)) uStage (
		.clk, .rstN, .decodeGroup,
		.mapSrc1, .mapSrc2, .mapDst,
		.freeIds, .freeCount,
		.rdSrc1, .rdSrc2, .rdDst,
		.wrEn, .wrAreg, .wrPreg,
		.allocCount, .stall, .renamedGroup
	);

	registerAliasTable #(.fetchWidth(fetchWidth)) uRat (
		.clk, .rstN,
		.rdSrc1, .rdSrc2, .rdDst,
		.wrEn, .wrAreg, .wrPreg,
		.mapSrc1, .mapSrc2, .mapDst
	);

	// Releases from commit go straight into the queue
	freeList #(.fetchWidth(fetchWidth)) uFreeList (
		.clk, .rstN, .allocCount, .releases,
		.freeIds, .freeCount
	);

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1; // Released away from the rising edge
	end

endmodule

// ==== testbench/renameUnit_checker.sv ====
`timescale 1ns/1ps

module renameUnitChecker #(
	parameter int fetchWidth = 2,
	localparam int countW = $clog2(renamePkg::freeDepth + 1)
) (
	input logic clk,
	input logic rstN,
	input renamePkg::renamedInstrT [fetchWidth-1:0] renamedGroup,
	input logic stall,
	input logic [countW-1:0] freeCount
);

	logic [fetchWidth-1:0] validBits;
	int failures = 0; // Failed assertion count, read by the testbench

	for (genvar i = 0; i < fetchWidth; i++) begin : gValid
		assign validBits[i] = renamedGroup[i].valid;
	end

	// **************************************************
	// Output and free list properties
	// **************************************************
	aResetEmpty: assert property (@(posedge clk) $rose(rstN) |-> validBits == '0)
		else begin
			failures++;
			$error("Renamed group valid right after reset");
		end

	aStallBubble: assert property (@(posedge clk) disable iff (!rstN) stall |=> validBits == '0)
		else begin
			failures++;
			$error("Stalled cycle was followed by a valid renamed slot");
		end

	// The queue can never hold more than the spare registers
	aCountBound: assert property (@(posedge clk) disable iff (!rstN)
		freeCount <= countW'(renamePkg::freeDepth))
		else begin
			failures++;
			$error("Free count above the free list depth");
		end

endmodule

// ==== testbench/renameTb.sv ====
`timescale 1ns/1ps

module renameTb;

	localparam int fetchWidth = 2;
	localparam int waitLimit = 200;

	logic clk;
	logic rstN;
	renamePkg::decodedInstrT [fetchWidth-1:0] decodeGroup;
	renamePkg::releaseT [fetchWidth-1:0] releases;
	renamePkg::renamedInstrT [fetchWidth-1:0] renamedGroup;
	logic stall;

	int seed = 32'hfe6a;
	string lastName = "reset";
	cpuPkg::pregT ratModel [cpuPkg::archRegs];
	cpuPkg::pregT freeModel [$];
	cpuPkg::pregT retired [$]; // Previous mappings waiting for commit
	renamePkg::renamedInstrT [fetchWidth-1:0] expGroup;
	logic expStall;

	clockGen uClock (.clk, .rstN);

	renameUnit #(.fetchWidth(fetchWidth)) DUT (
		.clk, .rstN, .decodeGroup, .releases, .renamedGroup, .stall
	);

	bind renameUnit renameUnitChecker #(.fetchWidth(fetchWidth)) uChecker (
		.clk, .rstN, .renamedGroup, .stall, .freeCount
	);

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// Only the valid bit matters in a bubble
	task automatic checkRenamed(input string name, input renamePkg::renamedInstrT exp,
			input renamePkg::renamedInstrT act);
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stopRun("Renamed instruction differs from the model");
		end
	endtask

	task automatic checkStall(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected stall %b, actual %b", name, exp, act);
			stopRun("Stall differs from the model");
		end
	endtask

	function automatic renamePkg::decodedInstrT makeInstr(input logic regWrite,
			input cpuPkg::aregT dst, input cpuPkg::aregT src1, input logic useImm,
			input logic [15:0] operand);
		renamePkg::decodedInstrT d;
		d.valid = 1'b1;
		d.pc = $random(seed);
		d.op = cpuPkg::opT'($random(seed));
		d.useImm = useImm;
		d.regWrite = regWrite;
		d.dst = dst;
		d.src1 = src1;
		d.operand.immForm = operand;
		if (!useImm) begin
			d.operand.regForm.src2 = cpuPkg::aregT'(operand);
			d.operand.regForm.pad = '0;
		end
		return d;
	endfunction

	function automatic renamePkg::decodedInstrT [fetchWidth-1:0] randomGroup();
		renamePkg::decodedInstrT [fetchWidth-1:0] g;
		for (int i = 0; i < fetchWidth; i++) begin
			g[i].valid = ($random(seed) & 3) != 0;
			g[i].pc = $random(seed);
			g[i].op = cpuPkg::opT'($random(seed));
			g[i].useImm = ($random(seed) & 3) == 0;
			g[i].regWrite = ($random(seed) & 3) != 0;
			g[i].dst = cpuPkg::aregT'($random(seed) & 15); // Small range makes hazards common
			g[i].src1 = cpuPkg::aregT'($random(seed) & 15);
			g[i].operand.immForm = 16'($random(seed));
		end
		return g;
	endfunction

	// **************************************************
	// Reference model that renames the slots one after another
	// **************************************************
	task automatic modelStep(input string name);
		int need;
		need = 0;
		for (int i = 0; i < fetchWidth; i++) begin
			if (decodeGroup[i].valid && decodeGroup[i].regWrite) begin
				need++;
			end
		end
		expStall = need > freeModel.size();
		checkStall(name, expStall, stall);
		for (int i = 0; i < fetchWidth; i++) begin
			expGroup[i] = '0;
			if (decodeGroup[i].valid && !expStall) begin
				expGroup[i].valid = 1'b1;
				expGroup[i].pc = decodeGroup[i].pc;
				expGroup[i].op = decodeGroup[i].op;
				expGroup[i].useImm = decodeGroup[i].useImm;
				expGroup[i].regWrite = decodeGroup[i].regWrite;
				expGroup[i].dst = decodeGroup[i].dst;
				expGroup[i].operand = decodeGroup[i].operand;
				expGroup[i].psrc1.valid = 1'b1;
				expGroup[i].psrc1.id = ratModel[decodeGroup[i].src1];
				if (!decodeGroup[i].useImm) begin
					expGroup[i].psrc2.valid = 1'b1;
					expGroup[i].psrc2.id = ratModel[decodeGroup[i].operand.regForm.src2];
				end
				if (decodeGroup[i].regWrite) begin
					expGroup[i].prevPdst = ratModel[decodeGroup[i].dst];
					expGroup[i].pdst = freeModel.pop_front();
					ratModel[decodeGroup[i].dst] = expGroup[i].pdst;
					retired.push_back(expGroup[i].prevPdst);
				end
			end
		end
		for (int i = 0; i < fetchWidth; i++) begin
			if (releases[i].valid) begin
				freeModel.push_back(releases[i].id);
			end
		end
	endtask

	// Checks last cycle's output, drives a new group and checks the stall
	task automatic stepCycle(input string name,
			input renamePkg::decodedInstrT [fetchWidth-1:0] group, input bit allowRelease);
		@(negedge clk);
		if (DUT.uChecker.failures != 0) begin
			stopRun("An assertion in the checker failed");
		end
		for (int i = 0; i < fetchWidth; i++) begin
			checkRenamed(lastName, expGroup[i], renamedGroup[i]);
		end
		decodeGroup = group;
		for (int i = 0; i < fetchWidth; i++) begin
			releases[i] = '0;
			if (allowRelease && retired.size() > 0 && ($random(seed) & 1) != 0) begin
				releases[i].valid = 1'b1;
				releases[i].id = retired.pop_front();
			end
		end
		#2;
		modelStep(name);
		lastName = name;
	endtask

	initial begin
		int cycles;
		int stalls;
		renamePkg::decodedInstrT [fetchWidth-1:0] g;
		decodeGroup = '0;
		releases = '0;
		expGroup = '0;
		for (int r = 0; r < cpuPkg::archRegs; r++) begin
			ratModel[r] = cpuPkg::pregT'(r);
		end
		for (int i = 0; i < renamePkg::freeDepth; i++) begin
			freeModel.push_back(cpuPkg::pregT'(cpuPkg::archRegs + i));
		end

		cycles = 0;
		while (rstN !== 1'b1) begin
			@(posedge clk);
			cycles++;
			if (cycles > waitLimit) begin
				stopRun("Reset was never released");
			end
		end
		@(negedge clk);
		for (int i = 0; i < fetchWidth; i++) begin
			checkRenamed("reset", '0, renamedGroup[i]);
		end
		checkStall("reset", 1'b0, stall);

		// First writer takes register 32 and reports its own dst as previous
		g = '0;
		g[0] = makeInstr(1'b1, 5'd5, 5'd3, 1'b0, 16'd4);
		stepCycle("firstWrite", g, 1'b0);
		g[0] = makeInstr(1'b1, 5'd7, 5'd1, 1'b0, 16'd2);
		g[1] = makeInstr(1'b1, 5'd7, 5'd7, 1'b0, 16'd7);
		stepCycle("intraGroup", g, 1'b0);
		g[0] = makeInstr(1'b1, 5'd9, 5'd7, 1'b1, 16'hbeef);
		g[1] = makeInstr(1'b0, 5'd0, 5'd9, 1'b1, 16'h1234);
		stepCycle("immediate", g, 1'b0);

		for (int n = 0; n < 300; n++) begin
			stepCycle("random", randomGroup(), 1'b1);
		end

		// **************************************************
		// Stall with releases withheld, then recovery
		// **************************************************
		stalls = 0;
		cycles = 0;
		while (stalls < 4) begin
			stepCycle("stall", randomGroup(), 1'b0);
			if (expStall) begin
				stalls++;
			end
			cycles++;
			if (cycles > waitLimit) begin
				stopRun("No stall seen while releases were withheld");
			end
		end
		cycles = 0;
		while (retired.size() > 0) begin
			stepCycle("drain", '0, 1'b1);
			cycles++;
			if (cycles > waitLimit) begin
				stopRun("Retired registers were not all released in time");
			end
		end
		for (int n = 0; n < 100; n++) begin
			stepCycle("resume", randomGroup(), 1'b1);
		end
		stepCycle("final", '0, 1'b0);

		if (DUT.uChecker.failures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stopRun("An assertion in the checker failed");
		end
	end

endmodule

// ==== all.f ====
common/cpuPkg.sv
common/renamePkg.sv
rename/rawCheck.sv
rename/registerAliasTable.sv
rename/freeList.sv
rename/renameStage.sv
hdl/renameUnit.sv
testbench/clockGen.sv
testbench/renameUnit_checker.sv
testbench/renameTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = renameTb
FILELIST = all.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Test FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Test FAILED"; exit 1; fi
	@echo "Test PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)
